//--- verilog/retire_stats_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Retirement statistics definitions
// Opcode, instruction class and window encodings shared by the monitor,
// plus the benchmark marker NOPs and the console UART data address
////////////////////////////////////////////////////////////////////////////

package retire_stats_pkg;

    localparam int INSTR_W = 32;

    // Classes that own a counter
    localparam int NUM_MIX_CLASSES = 7;

    // Benchmark marker NOPs (addi x0 x0 12 and addi x0 x0 13)
    localparam logic [INSTR_W-1:0] START_MARKER = 32'h00C0_0013;
    localparam logic [INSTR_W-1:0] END_MARKER   = 32'h00D0_0013;

    localparam logic [31:0] UART_TX_ADDR = 32'h8800_1000;

    // Major opcode field, instruction bits 6 to 2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_AMO      = 5'b01011,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_t;

    // Order matters, the first seven index the counters
    typedef enum logic [2:0] {
        MIX_ALU,
        MIX_BRANCH,
        MIX_MUL,
        MIX_DIV,
        MIX_LOAD,
        MIX_STORE,
        MIX_MISC,
        MIX_NONE
    } mix_class_t;

    typedef enum logic [1:0] {
        WIN_IDLE,
        WIN_COLLECTING,
        WIN_DONE
    } window_state_t;

endpackage

//--- verilog/retire_class_if.sv
////////////////////////////////////////////////////////////////////////////
// Decoded retirement bus
// Per-port valid, class and marker flags from the retire decoders
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface retire_class_if #(
    parameter int NUM_PORTS = 2
);

    logic                         valid     [NUM_PORTS];
    retire_stats_pkg::mix_class_t mix_class [NUM_PORTS];
    logic                         is_start  [NUM_PORTS];
    logic                         is_end    [NUM_PORTS];

    // Each decoder drives its own slot
    modport source (
        output valid,
        output mix_class,
        output is_start,
        output is_end
    );

    modport sink (
        input valid,
        input mix_class,
        input is_start,
        input is_end
    );

endinterface

//--- verilog/retire_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Retire port decoder
// Sorts one retired instruction into its mix class and spots the
// benchmark marker NOPs, one register stage onto the class bus
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_decoder #(
    parameter int PORT_IDX = 0
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 retire_valid,
    input  logic [retire_stats_pkg::INSTR_W-1:0] instruction,
    retire_class_if.source                       class_bus
);

    retire_stats_pkg::opcode_t    opcode;
    retire_stats_pkg::mix_class_t class_d;
    retire_stats_pkg::mix_class_t class_q;
    logic                         valid_q;
    logic                         start_q;
    logic                         end_q;

    assign opcode = retire_stats_pkg::opcode_t'(instruction[6:2]);

    always_comb begin
        case (opcode)
            retire_stats_pkg::OPC_OP: begin
                // M extension shares the OP major opcode, funct7 bit 0 set
                if (instruction[25]) begin
                    class_d = instruction[14] ? retire_stats_pkg::MIX_DIV
                                              : retire_stats_pkg::MIX_MUL;
                end else begin
                    class_d = retire_stats_pkg::MIX_ALU;
                end
            end
            retire_stats_pkg::OPC_OP_IMM,
            retire_stats_pkg::OPC_AUIPC,
            retire_stats_pkg::OPC_LUI:      class_d = retire_stats_pkg::MIX_ALU;
            retire_stats_pkg::OPC_BRANCH,
            retire_stats_pkg::OPC_JAL,
            retire_stats_pkg::OPC_JALR:     class_d = retire_stats_pkg::MIX_BRANCH;
            retire_stats_pkg::OPC_LOAD:     class_d = retire_stats_pkg::MIX_LOAD;
            retire_stats_pkg::OPC_STORE:    class_d = retire_stats_pkg::MIX_STORE;
            retire_stats_pkg::OPC_SYSTEM,
            retire_stats_pkg::OPC_MISC_MEM: class_d = retire_stats_pkg::MIX_MISC;
            // AMO and anything unknown stays out of the mix
            default:                        class_d = retire_stats_pkg::MIX_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            start_q <= 1'b0;
            end_q   <= 1'b0;
        end else begin
            valid_q <= retire_valid;
            start_q <= retire_valid && (instruction == retire_stats_pkg::START_MARKER);
            end_q   <= retire_valid && (instruction == retire_stats_pkg::END_MARKER);
        end
    end

    always_ff @(posedge clk) begin
        class_q <= class_d;
    end

    assign class_bus.valid[PORT_IDX]     = valid_q;
    assign class_bus.mix_class[PORT_IDX] = class_q;
    assign class_bus.is_start[PORT_IDX]  = start_q;
    assign class_bus.is_end[PORT_IDX]    = end_q;

    // Both markers are addi x0 encodings and must decode as ALU
    a_marker_is_alu: assert property (@(posedge clk) disable iff (!rst_n)
        (class_bus.is_start[PORT_IDX] || class_bus.is_end[PORT_IDX]) |->
            class_bus.mix_class[PORT_IDX] == retire_stats_pkg::MIX_ALU);

endmodule

//--- verilog/collection_window.sv
////////////////////////////////////////////////////////////////////////////
// Collection window FSM
// Opens on a start marker NOP, closes on an end marker NOP and pulses
// clear whenever a window opens or restarts
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module collection_window #(
    parameter int NUM_PORTS = 2
) (
    input  logic         clk,
    input  logic         rst_n,
    retire_class_if.sink class_bus,
    output logic         collecting,
    output logic         clear,
    output logic         collection_done
);

    retire_stats_pkg::window_state_t state_q;
    retire_stats_pkg::window_state_t state_d;
    logic                            start_any;
    logic                            end_any;

    always_comb begin
        start_any = 1'b0;
        end_any   = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            start_any |= class_bus.is_start[p];
            end_any   |= class_bus.is_end[p];
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            retire_stats_pkg::WIN_IDLE,
            retire_stats_pkg::WIN_DONE: begin
                if (start_any) state_d = retire_stats_pkg::WIN_COLLECTING;
            end
            retire_stats_pkg::WIN_COLLECTING: begin
                // Another start restarts, so it wins over an end
                if (!start_any && end_any) state_d = retire_stats_pkg::WIN_DONE;
            end
            default: state_d = retire_stats_pkg::WIN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= retire_stats_pkg::WIN_IDLE;
            clear   <= 1'b0;
        end else begin
            state_q <= state_d;
            clear   <= start_any;
        end
    end

    assign collecting      = (state_q == retire_stats_pkg::WIN_COLLECTING);
    assign collection_done = (state_q == retire_stats_pkg::WIN_DONE);

    a_no_start_end_together: assert property (@(posedge clk) disable iff (!rst_n)
        !(start_any && end_any));

endmodule

//--- verilog/mix_counters.sv
////////////////////////////////////////////////////////////////////////////
// Instruction mix counters
// One counter per class, summed over all retire ports while the
// window is open, read back through a registered select mux
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mix_counters #(
    parameter int NUM_PORTS = 2,
    parameter int COUNT_W   = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    retire_class_if.sink                 class_bus,
    input  logic                         collecting,
    input  logic                         clear,
    input  retire_stats_pkg::mix_class_t count_sel,
    output logic [COUNT_W-1:0]           count_value
);

    localparam int NCLS  = retire_stats_pkg::NUM_MIX_CLASSES;
    localparam int INC_W = $clog2(NUM_PORTS + 1);

    logic [INC_W-1:0]   inc    [NCLS];
    logic [COUNT_W-1:0] counts [NCLS];

    // Retirements per class this cycle, markers excluded
    always_comb begin
        for (int c = 0; c < NCLS; c++) begin
            inc[c] = '0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (class_bus.valid[p] && !class_bus.is_start[p] && !class_bus.is_end[p] &&
                    class_bus.mix_class[p] == retire_stats_pkg::mix_class_t'(c)) begin
                    inc[c] = inc[c] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NCLS; c++) begin
                counts[c] <= '0;
            end
        end else begin
            for (int c = 0; c < NCLS; c++) begin
                // Restart drops the old total but keeps the first cycle in the window
                if (clear) begin
                    counts[c] <= COUNT_W'(inc[c]);
                end else if (collecting) begin
                    counts[c] <= counts[c] + COUNT_W'(inc[c]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_value <= '0;
        end else if (int'(count_sel) < NCLS) begin
            count_value <= counts[count_sel];
        end else begin
            count_value <= '0;
        end
    end

    // Totals only grow between clears
    for (genvar c = 0; c < NCLS; c++) begin : g_wrap_chk
        a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
            !clear |=> counts[c] >= $past(counts[c]));
    end

endmodule

//--- verilog/uart_capture.sv
////////////////////////////////////////////////////////////////////////////
// Console UART snoop
// Watches AXI write beats and strobes out the byte sent to the UART
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module uart_capture #(
    parameter logic [31:0] UART_ADDR = retire_stats_pkg::UART_TX_ADDR
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] axi_awaddr,
    input  logic        axi_wvalid,
    input  logic        axi_wready,
    input  logic [31:0] axi_wdata,
    output logic        uart_write,
    output logic [7:0]  uart_byte
);

    logic beat_hit;

    assign beat_hit = axi_wvalid && axi_wready && (axi_awaddr == UART_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) uart_write <= 1'b0;
        else        uart_write <= beat_hit;
    end

    // Byte holds until the next UART beat
    always_ff @(posedge clk) begin
        if (beat_hit) uart_byte <= axi_wdata[7:0];
    end

endmodule

//--- verilog/retire_stats_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Retirement statistics monitor
// Classifies instructions on the core's retire ports, counts the mix
// inside the benchmark window and snoops console UART writes on AXI
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_stats_monitor #(
    parameter int          NUM_PORTS = 2,
    parameter int          COUNT_W   = 32,
    parameter logic [31:0] UART_ADDR = retire_stats_pkg::UART_TX_ADDR
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    // Retire ports
    input  logic [NUM_PORTS-1:0]                                retire_valid,
    input  logic [NUM_PORTS-1:0][retire_stats_pkg::INSTR_W-1:0] retire_instruction,
    // AXI write snoop
    input  logic [31:0]                                         axi_awaddr,
    input  logic                                                axi_wvalid,
    input  logic                                                axi_wready,
    input  logic [31:0]                                         axi_wdata,
    // Statistics readout
    input  retire_stats_pkg::mix_class_t                        count_sel,
    output logic [COUNT_W-1:0]                                  count_value,
    output logic                                                collecting,
    output logic                                                collection_done,
    // Console
    output logic                                                uart_write,
    output logic [7:0]                                          uart_byte
);

    logic clear;

    retire_class_if #(.NUM_PORTS(NUM_PORTS)) class_bus ();

    ////////////////////////////////////////////////////////////////////////////
    // Per-port decode
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_decoder
        retire_decoder #(
            .PORT_IDX (p)
        ) decoder_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .retire_valid (retire_valid[p]),
            .instruction  (retire_instruction[p]),
            .class_bus    (class_bus.source)
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Window and counters
    collection_window #(
        .NUM_PORTS (NUM_PORTS)
    ) window_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .class_bus       (class_bus.sink),
        .collecting      (collecting),
        .clear           (clear),
        .collection_done (collection_done)
    );

    mix_counters #(
        .NUM_PORTS (NUM_PORTS),
        .COUNT_W   (COUNT_W)
    ) counters_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .class_bus   (class_bus.sink),
        .collecting  (collecting),
        .clear       (clear),
        .count_sel   (count_sel),
        .count_value (count_value)
    );

    uart_capture #(
        .UART_ADDR (UART_ADDR)
    ) uart_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .axi_awaddr (axi_awaddr),
        .axi_wvalid (axi_wvalid),
        .axi_wready (axi_wready),
        .axi_wdata  (axi_wdata),
        .uart_write (uart_write),
        .uart_byte  (uart_byte)
    );

endmodule

//--- tests/tb_retire_stats_monitor.sv
////////////////////////////////////////////////////////////////////////////
// Retirement statistics monitor testbench
// Directed tests against a per-class reference model of the window and
// instruction mix rules, plus console UART snoop checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_retire_stats_monitor;

    localparam int          NUM_PORTS      = 2;
    localparam int          COUNT_W        = 32;
    localparam int          UART_TIMEOUT   = 16;
    localparam logic [31:0] START_WORD     = 32'h00C0_0013;
    localparam logic [31:0] END_WORD       = 32'h00D0_0013;
    localparam logic [31:0] UART_DATA_ADDR = 32'h8800_1000;

    logic                         clk;
    logic                         rst_n;
    logic [NUM_PORTS-1:0]         retire_valid;
    logic [NUM_PORTS-1:0][31:0]   retire_instruction;
    logic [31:0]                  axi_awaddr;
    logic                         axi_wvalid;
    logic                         axi_wready;
    logic [31:0]                  axi_wdata;
    retire_stats_pkg::mix_class_t count_sel;
    logic [COUNT_W-1:0]           count_value;
    logic                         collecting;
    logic                         collection_done;
    logic                         uart_write;
    logic [7:0]                   uart_byte;

    int seed        = 25885;
    int error_count = 0;
    int check_count = 0;
    int test_count  = 0;

    // Reference model, index 7 is the unclassified bucket
    int model_cnt [8];
    bit model_open;
    bit model_done;

    // Legal major opcodes for the random mix
    logic [4:0] legal_opc [12] = '{5'b00000, 5'b00011, 5'b00100, 5'b00101,
                                   5'b01000, 5'b01011, 5'b01100, 5'b01101,
                                   5'b11000, 5'b11001, 5'b11011, 5'b11100};

    retire_stats_monitor #(
        .NUM_PORTS (NUM_PORTS),
        .COUNT_W   (COUNT_W)
    ) dut_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .retire_valid       (retire_valid),
        .retire_instruction (retire_instruction),
        .axi_awaddr         (axi_awaddr),
        .axi_wvalid         (axi_wvalid),
        .axi_wready         (axi_wready),
        .axi_wdata          (axi_wdata),
        .count_sel          (count_sel),
        .count_value        (count_value),
        .collecting         (collecting),
        .collection_done    (collection_done),
        .uart_write         (uart_write),
        .uart_byte          (uart_byte)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Class index from the major opcode and the M extension bits
    function automatic int expected_class(input logic [31:0] w);
        case (w[6:2])
            5'b01100: begin
                if (w[25]) return w[14] ? 3 : 2;
                return 0;
            end
            5'b00100, 5'b00101, 5'b01101: return 0;
            5'b11000, 5'b11001, 5'b11011: return 1;
            5'b00000:                     return 4;
            5'b01000:                     return 5;
            5'b11100, 5'b00011:           return 6;
            default:                      return 7;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
        end
    endtask

    task automatic count_port(input logic v, input logic [31:0] w);
        if (v && w != START_WORD && w != END_WORD) begin
            model_cnt[expected_class(w)]++;
        end
    endtask

    // One retire cycle on both ports, model follows the window rules
    task automatic retire(input logic v0, input logic [31:0] w0,
                          input logic v1, input logic [31:0] w1);
        bit start_seen;
        bit end_seen;
        start_seen = (v0 && w0 == START_WORD) || (v1 && w1 == START_WORD);
        end_seen   = (v0 && w0 == END_WORD) || (v1 && w1 == END_WORD);
        @(posedge clk);
        retire_valid       <= {v1, v0};
        retire_instruction <= {w1, w0};
        if (start_seen) begin
            for (int c = 0; c < 8; c++) model_cnt[c] = 0;
            model_open = 1'b1;
            model_done = 1'b0;
        end else if (model_open) begin
            count_port(v0, w0);
            count_port(v1, w1);
            if (end_seen) begin
                model_open = 1'b0;
                model_done = 1'b1;
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            retire_valid <= '0;
        end
    endtask

    task automatic read_count(input int sel, output logic [31:0] value);
        @(posedge clk);
        count_sel <= retire_stats_pkg::mix_class_t'(sel);
        repeat (2) @(posedge clk);
        @(negedge clk);
        value = count_value;
    endtask

    // Let the pipeline drain, then compare every class and the window flags
    task automatic check_counts(input string name);
        logic [31:0] value;
        idle_cycles(4);
        for (int c = 0; c < 8; c++) begin
            read_count(c, value);
            check_value($sformatf("%s class %0d", name, c), (c < 7) ? model_cnt[c] : 0, value);
        end
        check_value({name, " collecting"}, model_open, collecting);
        check_value({name, " collection_done"}, model_done, collection_done);
    endtask

    task automatic end_test(input string name, input int errors_before);
        test_count++;
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        @(negedge clk);
        check_value("reset uart_write", 0, uart_write);
        check_counts("reset");
        end_test("reset", errors_before);
    endtask

    task automatic test_classification();
        int errors_before;
        logic [31:0] words [12] = '{32'h0031_00B3, 32'h0051_0093, 32'h1234_50B7,
                                   32'h0231_00B3, 32'h0231_40B3, 32'h0020_8063,
                                   32'h0000_00EF, 32'h0001_2083, 32'h0011_2023,
                                   32'h0000_0073, 32'h0FF0_000F, 32'h0021_A0AF};
        errors_before = error_count;
        retire(1'b1, START_WORD, 1'b0, '0);
        foreach (words[i]) retire(1'b1, words[i], 1'b0, '0);
        retire(1'b1, END_WORD, 1'b0, '0);
        check_counts("classification");
        end_test("classification", errors_before);
    endtask

    task automatic test_window();
        int errors_before;
        errors_before = error_count;
        retire(1'b1, 32'h0031_00B3, 1'b0, '0);
        // Totals from the closed window must still stand
        check_counts("window_before_start");
        retire(1'b1, START_WORD, 1'b1, 32'h0031_00B3);
        retire(1'b1, 32'h0001_2083, 1'b0, '0);
        retire(1'b1, 32'h0011_2023, 1'b1, END_WORD);
        retire(1'b1, 32'h0031_00B3, 1'b1, 32'h0231_00B3);
        check_counts("window");
        end_test("window", errors_before);
    endtask

    task automatic test_random_mix();
        int errors_before;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] v;
        errors_before = error_count;
        retire(1'b1, START_WORD, 1'b0, '0);
        // Same class on both ports in one cycle
        retire(1'b1, 32'h0231_00B3, 1'b1, 32'h0231_00B3);
        check_counts("dual_port");
        for (int i = 0; i < 200; i++) begin
            w0 = $random(seed);
            w1 = $random(seed);
            v  = $random(seed);
            w0[6:0] = {legal_opc[$unsigned($random(seed)) % 12], 2'b11};
            w1[6:0] = {legal_opc[$unsigned($random(seed)) % 12], 2'b11};
            retire(v[0], w0, v[1], w1);
        end
        check_counts("random_mix");
        end_test("random_mix", errors_before);
    endtask

    task automatic test_restart();
        int errors_before;
        errors_before = error_count;
        retire(1'b1, 32'h0031_00B3, 1'b1, 32'h0051_0093);
        retire(1'b0, '0, 1'b1, START_WORD);
        retire(1'b1, 32'h0001_2083, 1'b1, 32'h0020_8063);
        retire(1'b1, 32'h0000_0073, 1'b0, '0);
        check_counts("restart");
        end_test("restart", errors_before);
    endtask

    task automatic uart_beat(input string name, input logic [31:0] addr,
                             input logic ready, input bit expect_pulse);
        int  t;
        bit  hit;
        @(posedge clk);
        axi_awaddr <= addr;
        axi_wvalid <= 1'b1;
        axi_wready <= ready;
        axi_wdata  <= 32'h1234_5641;
        @(posedge clk);
        axi_wvalid <= 1'b0;
        axi_wready <= 1'b0;
        t   = 0;
        hit = 1'b0;
        while (!hit && t < UART_TIMEOUT) begin
            @(negedge clk);
            hit = uart_write;
            t++;
        end
        if (expect_pulse && !hit) begin
            error_count++;
            $display("%s: uart_write never pulsed within %0d cycles", name, UART_TIMEOUT);
        end else if (expect_pulse) begin
            check_value({name, " uart_byte"}, 8'h41, uart_byte);
            @(negedge clk);
            check_value({name, " pulse width"}, 0, uart_write);
        end else begin
            check_value({name, " uart_write"}, 0, hit);
        end
    endtask

    task automatic test_uart();
        int errors_before;
        errors_before = error_count;
        uart_beat("uart_hit", UART_DATA_ADDR, 1'b1, 1'b1);
        uart_beat("uart_other_addr", UART_DATA_ADDR + 32'h4, 1'b1, 1'b0);
        uart_beat("uart_not_ready", UART_DATA_ADDR, 1'b0, 1'b0);
        end_test("uart", errors_before);
    endtask

    initial begin
        rst_n              = 1'b0;
        retire_valid       = '0;
        retire_instruction = '0;
        axi_awaddr         = '0;
        axi_wvalid         = 1'b0;
        axi_wready         = 1'b0;
        axi_wdata          = '0;
        count_sel          = retire_stats_pkg::MIX_ALU;
        model_open         = 1'b0;
        model_done         = 1'b0;
        for (int c = 0; c < 8; c++) model_cnt[c] = 0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_reset();
        test_classification();
        test_window();
        test_random_mix();
        test_restart();
        test_uart();

        $display("tests %0d checks %0d errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/retire_stats_pkg.sv
verilog/retire_class_if.sv
verilog/retire_decoder.sv
verilog/collection_window.sv
verilog/mix_counters.sv
verilog/uart_capture.sv
verilog/retire_stats_monitor.sv
tests/tb_retire_stats_monitor.sv

//--- Bender.yml
package:
  name: retire_stats_monitor

sources:
  - verilog/retire_stats_pkg.sv
  - verilog/retire_class_if.sv
  - verilog/retire_decoder.sv
  - verilog/collection_window.sv
  - verilog/mix_counters.sv
  - verilog/uart_capture.sv
  - verilog/retire_stats_monitor.sv
  - target: test
    files:
      - tests/tb_retire_stats_monitor.sv
